// File: common/cpuPkg.sv
package cpuPkg;

	localparam int IMEM_DEPTH = 128;
	localparam int DMEM_DEPTH = 256;
	localparam int NUM_REGS   = 32;
	localparam int HEX_DIGITS = 4;

	typedef logic [15:0] word_t;
	typedef logic [31:0] instr_t;
	typedef logic [6:0]  pcAddr_t;
	typedef logic [4:0]  regIdx_t;
	typedef logic [7:0]  memAddr_t;

	typedef enum logic [3:0] {
		OP_NOP   = 4'd0,
		OP_ADD   = 4'd1,
		OP_SUB   = 4'd2,
		OP_AND   = 4'd3,
		OP_OR    = 4'd4,
		OP_XOR   = 4'd5,
		OP_SLT   = 4'd6,
		OP_SHL   = 4'd7,
		OP_JMP   = 4'd8,
		OP_STORE = 4'd10,
		OP_LOAD  = 4'd11,
		OP_LDI   = 4'd12,
		OP_BNZ   = 4'd13
	} opcode_e;

	// same codes as the ALU opcodes
	typedef enum logic [2:0] {
		ALU_ADD = 3'd1,
		ALU_SUB = 3'd2,
		ALU_AND = 3'd3,
		ALU_OR  = 3'd4,
		ALU_XOR = 3'd5,
		ALU_SLT = 3'd6,
		ALU_SHL = 3'd7
	} aluFunc_e;

	typedef struct packed {
		opcode_e opcode;
		logic    spare;
		regIdx_t rd;
		regIdx_t rs;
		logic    useImm;
		word_t   imm;
	} instrFields_t;

	typedef struct packed {
		aluFunc_e aluFunc;
		logic     useImm;
		logic     regWrite;
		logic     memRead;
		logic     memWrite;
		logic     loadImm;
		logic     jump;
		logic     branchNz;
		logic     setFlags;
	} ctrl_t;

	typedef struct packed {
		logic zero;
		logic negative;
		logic carry;
		logic overflow;
	} flags_t;

	typedef struct packed {
		logic    we;
		pcAddr_t addr;
		instr_t  data;
	} progWrite_t;

	typedef struct packed {
		logic    valid;
		regIdx_t dest;
		word_t   data;
	} writeBack_t;

endpackage

// File: core/instMem.sv
`timescale 1ns/10ps

module instMem (
	input  logic                clk,
	input  cpuPkg::progWrite_t  prog,
	input  logic                hold,
	input  cpuPkg::pcAddr_t     addr,
	output cpuPkg::instr_t      instr
);
	import cpuPkg::*;

	instr_t mem [IMEM_DEPTH];

	// load port only while the core is held
	always_ff @(posedge clk) begin
		if (prog.we && hold) begin
			mem[prog.addr] <= prog.data;
		end
	end

	assign instr = mem[addr];

endmodule

// File: core/instDecoder.sv
`timescale 1ns/10ps

module instDecoder (
	input  cpuPkg::opcode_e opcode,
	input  logic            useImmBit,
	output cpuPkg::ctrl_t   ctrl
);
	import cpuPkg::*;

	logic [3:0] opBits;

	assign opBits = opcode;

	always_comb begin
		ctrl = '0;
		// address math for load and store also runs through the adder
		ctrl.aluFunc = ALU_ADD;
		case (opcode)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SHL: begin
				ctrl.aluFunc  = aluFunc_e'(opBits[2:0]);
				ctrl.useImm   = useImmBit;
				ctrl.regWrite = 1'b1;
				ctrl.setFlags = 1'b1;
			end
			OP_JMP: begin
				ctrl.jump = 1'b1;
			end
			OP_STORE: begin
				ctrl.useImm   = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			OP_LOAD: begin
				ctrl.useImm   = 1'b1;
				ctrl.memRead  = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			OP_LDI: begin
				ctrl.loadImm  = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			OP_BNZ: begin
				ctrl.branchNz = 1'b1;
			end
			default: begin
				// unused codes act as nop
			end
		endcase
	end

endmodule

// File: core/alu.sv
`timescale 1ns/10ps

module alu (
	input  cpuPkg::word_t    a,
	input  cpuPkg::word_t    b,
	input  cpuPkg::aluFunc_e func,
	output cpuPkg::word_t    result,
	output cpuPkg::flags_t   rawFlags
);
	import cpuPkg::*;

	logic        subtract;
	word_t       bOp;
	logic [16:0] sum;
	logic        less;
	word_t       shift1;
	word_t       shift2;

	//////////////////////////////////////////////////////////////////////
	// shared adder since slt needs the difference too
	assign subtract = (func == ALU_SUB) || (func == ALU_SLT);
	assign bOp      = subtract ? ~b : b;
	assign sum      = {1'b0, a} + {1'b0, bOp} + 17'(subtract);

	// a negative a wins when the signs differ and the difference sign decides otherwise
	assign less = (a[15] & ~b[15]) | (~(a[15] ^ b[15]) & sum[15]);

	// two-stage shifter by 1 then by 2
	assign shift1 = b[0] ? {a[14:0], 1'b0} : a;
	assign shift2 = b[1] ? {shift1[13:0], 2'b00} : shift1;

	always_comb begin
		case (func)
			ALU_ADD, ALU_SUB: result = sum[15:0];
			ALU_AND:          result = a & b;
			ALU_OR:           result = a | b;
			ALU_XOR:          result = a ^ b;
			ALU_SLT:          result = {15'd0, less};
			ALU_SHL:          result = shift2;
			default:          result = sum[15:0];
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	assign rawFlags.zero     = (result == '0);
	assign rawFlags.negative = result[15];
	assign rawFlags.carry    = sum[16];
	assign rawFlags.overflow = (a[15] == bOp[15]) && (sum[15] != a[15]);

endmodule

// File: core/regFile.sv
`timescale 1ns/10ps

module regFile (
	input  logic                clk,
	input  logic                rst,
	input  cpuPkg::regIdx_t     rdIdxA,
	input  cpuPkg::regIdx_t     rdIdxB,
	output cpuPkg::word_t       rdDataA,
	output cpuPkg::word_t       rdDataB,
	input  cpuPkg::writeBack_t  wr
);
	import cpuPkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.valid) begin
			regs[wr.dest] <= wr.data;
		end
	end

	// r0 is hardwired
	assign rdDataA = (rdIdxA == '0) ? '0 : regs[rdIdxA];
	assign rdDataB = (rdIdxB == '0) ? '0 : regs[rdIdxB];

endmodule

// File: core/cpuCore.sv
`timescale 1ns/10ps

module cpuCore (
	input  logic                clk,
	input  logic                rst,
	input  logic                run,
	input  cpuPkg::progWrite_t  prog,
	output cpuPkg::pcAddr_t     pc,
	output cpuPkg::writeBack_t  wb,
	output cpuPkg::flags_t      flags
);
	import cpuPkg::*;

	instr_t       memInstr;
	instr_t       fetchReg;
	instrFields_t ir;
	ctrl_t        ctrl;
	regIdx_t      rdIdxB;
	word_t        rdDataA;
	word_t        rdDataB;
	word_t        operandB;
	word_t        aluResult;
	flags_t       rawFlags;
	memAddr_t     memAddr;
	writeBack_t   wbNext;
	logic         exec;
	logic         taken;
	logic         arith;
	word_t        dataMem [DMEM_DEPTH];

	instMem u_instMem (.clk(clk), .prog(prog), .hold(~run), .addr(pc), .instr(memInstr));

	//////////////////////////////////////////////////////////////////////
	// execute stage
	assign ir   = fetchReg;
	assign exec = run && rst;

	instDecoder u_instDecoder (.opcode(ir.opcode), .useImmBit(ir.useImm), .ctrl(ctrl));

	// store and bnz read rd on the second port
	assign rdIdxB = (ctrl.memWrite || ctrl.branchNz) ? ir.rd : regIdx_t'(ir.imm[4:0]);

	regFile u_regFile (
		.clk(clk), .rst(rst),
		.rdIdxA(ir.rs), .rdIdxB(rdIdxB),
		.rdDataA(rdDataA), .rdDataB(rdDataB),
		.wr(wbNext)
	);

	assign operandB = ctrl.useImm ? ir.imm : rdDataB;

	alu u_alu (.a(rdDataA), .b(operandB), .func(ctrl.aluFunc), .result(aluResult),
		.rawFlags(rawFlags));

	assign memAddr = aluResult[7:0];
	assign taken   = exec && (ctrl.jump || (ctrl.branchNz && rdDataB != '0));
	assign arith   = (ctrl.aluFunc == ALU_ADD) || (ctrl.aluFunc == ALU_SUB);

	assign wbNext.valid = exec && ctrl.regWrite && (ir.rd != '0);
	assign wbNext.dest  = ir.rd;
	assign wbNext.data  = ctrl.loadImm ? ir.imm : (ctrl.memRead ? dataMem[memAddr] : aluResult);

	always_ff @(posedge clk) begin
		if (exec && ctrl.memWrite) begin
			dataMem[memAddr] <= rdDataB;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// pc, fetch register, flags and write-back record
	always_ff @(posedge clk) begin
		if (!exec) begin
			pc       <= '0;
			fetchReg <= instr_t'({OP_NOP, 28'd0});
		end else begin
			pc       <= taken ? ir.imm[6:0] : pc + 1'b1;
			fetchReg <= memInstr;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			flags <= '0;
			wb    <= '0;
		end else begin
			wb <= wbNext;
			if (exec && ctrl.setFlags) begin
				flags.zero     <= rawFlags.zero;
				flags.negative <= rawFlags.negative;
				// carry and overflow only mean something for add and sub
				if (arith) begin
					flags.carry    <= rawFlags.carry;
					flags.overflow <= rawFlags.overflow;
				end
			end
		end
	end

endmodule

// File: logic/hexDisplay.sv
`timescale 1ns/10ps

module hexDisplay (
	input  logic                                 clk,
	input  logic                                 rst,
	input  cpuPkg::writeBack_t                   wb,
	output logic [cpuPkg::HEX_DIGITS-1:0][6:0]   hex
);
	import cpuPkg::*;

	// active low with bit 6 as segment g
	function automatic logic [6:0] segOf(input logic [3:0] nib);
		case (nib)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'hA: return 7'b0001000;
			4'hB: return 7'b0000011;
			4'hC: return 7'b1000110;
			4'hD: return 7'b0100001;
			4'hE: return 7'b0000110;
			default: return 7'b0001110;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < HEX_DIGITS; i++) begin
				hex[i] <= segOf(4'h0);
			end
		end else if (wb.valid) begin
			for (int i = 0; i < HEX_DIGITS; i++) begin
				hex[i] <= segOf(wb.data[i*4 +: 4]);
			end
		end
	end

endmodule

// File: logic/cpuTop.sv
`timescale 1ns/10ps

module cpuTop (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 run,
	input  cpuPkg::progWrite_t                   prog,
	output cpuPkg::pcAddr_t                      pc,
	output cpuPkg::writeBack_t                   wb,
	output cpuPkg::flags_t                       flags,
	output logic [cpuPkg::HEX_DIGITS-1:0][6:0]   hex
);
	import cpuPkg::*;

	cpuCore u_cpuCore (
		.clk   (clk),
		.rst   (rst),
		.run   (run),
		.prog  (prog),
		.pc    (pc),
		.wb    (wb),
		.flags (flags)
	);

	// shows the last value written back
	hexDisplay u_hexDisplay (
		.clk (clk),
		.rst (rst),
		.wb  (wb),
		.hex (hex)
	);

endmodule

// File: verif/cpuTop_props.sv
`timescale 1ns/10ps

module cpuTop_props (
	input logic               clk,
	input logic               rst,
	input logic               run,
	input cpuPkg::pcAddr_t    pc,
	input cpuPkg::writeBack_t wb
);
	int failCount = 0;

	// a held core restarts from address 0
	pcCleared: assert property (@(posedge clk) !run |=> pc == '0)
		else begin
			$error("pc not cleared one cycle after run went low");
			failCount++;
		end

	destNonzero: assert property (@(posedge clk) wb.valid |-> wb.dest != '0)
		else begin
			$error("write-back to register 0");
			failCount++;
		end

	wbQuiet: assert property (@(posedge clk) !rst |=> !wb.valid)
		else begin
			$error("write-back valid right after reset");
			failCount++;
		end

endmodule

bind cpuTop cpuTop_props u_cpuTopProps (.clk(clk), .rst(rst), .run(run), .pc(pc), .wb(wb));

// File: verif/cpuTop_tb.sv
`timescale 1ns/10ps

module cpuTop_tb;
	import cpuPkg::*;

	logic                       clk;
	logic                       rst;
	logic                       run;
	progWrite_t                 prog;
	pcAddr_t                    pc;
	writeBack_t                 wb;
	flags_t                     flags;
	logic [HEX_DIGITS-1:0][6:0] hex;

	instr_t     code [$];
	writeBack_t gotWb [$];
	flags_t     gotFlags [$];
	writeBack_t expWb [$];
	flags_t     expFlags [$];
	word_t      modelRegs [NUM_REGS];
	word_t      modelMem [DMEM_DEPTH];
	flags_t     modelFlags;
	int         errors = 0;
	int         errorsBefore = 0;
	int         testsRun = 0;

	// digits 0 to F in active low with g as bit 6
	logic [6:0] segTable [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};

	cpuTop u_cpuTop (.clk(clk), .rst(rst), .run(run), .prog(prog), .pc(pc), .wb(wb),
		.flags(flags), .hex(hex));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	function automatic void emit(opcode_e op, int rd, int rs, logic useImm, int imm);
		code.push_back({op, 1'b0, regIdx_t'(rd), regIdx_t'(rs), useImm, word_t'(imm)});
	endfunction

	// jump to itself with a nop in the delay slot
	function automatic void addHalt();
		int here;
		here = code.size();
		emit(OP_JMP, 0, 0, 1'b0, here);
		emit(OP_NOP, 0, 0, 1'b0, 0);
	endfunction

	function automatic void modelReset();
		foreach (modelRegs[i]) begin
			modelRegs[i] = '0;
		end
		modelFlags = '0;
	endfunction

	function automatic logic [HEX_DIGITS*7-1:0] hexOf(word_t value);
		logic [HEX_DIGITS*7-1:0] segs;
		for (int i = 0; i < HEX_DIGITS; i++) begin
			segs[i*7 +: 7] = segTable[value[i*4 +: 4]];
		end
		return segs;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// instruction set model with one delay slot after jmp and bnz
	function automatic void modelRun();
		int           cur;
		int           next;
		int           after;
		int           wide;
		logic         alu;
		instrFields_t f;
		word_t        a;
		word_t        b;
		word_t        r;
		memAddr_t     addr;
		expWb.delete();
		expFlags.delete();
		cur = 0;
		next = 1;
		repeat (600) begin
			f = (cur < code.size()) ? code[cur] : '0;
			a = modelRegs[f.rs];
			b = f.useImm ? f.imm : modelRegs[f.imm[4:0]];
			addr = memAddr_t'(a + f.imm);
			after = (next + 1) % IMEM_DEPTH;
			alu = (f.opcode >= OP_ADD) && (f.opcode <= OP_SHL);
			r = '0;
			case (f.opcode)
				OP_ADD: begin
					r = a + b;
					wide = int'($signed(a)) + int'($signed(b));
					modelFlags.carry = (int'(a) + int'(b)) > 65535;
					modelFlags.overflow = (wide > 32767) || (wide < -32768);
				end
				OP_SUB: begin
					r = a - b;
					wide = int'($signed(a)) - int'($signed(b));
					// carry set means no borrow
					modelFlags.carry = (a >= b);
					modelFlags.overflow = (wide > 32767) || (wide < -32768);
				end
				OP_AND: r = a & b;
				OP_OR: r = a | b;
				OP_XOR: r = a ^ b;
				OP_SLT: r = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
				OP_SHL: r = a << b[1:0];
				OP_JMP: after = f.imm[6:0];
				OP_STORE: modelMem[addr] = modelRegs[f.rd];
				OP_LOAD: r = modelMem[addr];
				OP_LDI: r = f.imm;
				OP_BNZ: begin
					if (modelRegs[f.rd] != '0) begin
						after = f.imm[6:0];
					end
				end
				default: begin
				end
			endcase
			if (alu) begin
				modelFlags.zero = (r == '0);
				modelFlags.negative = r[15];
			end
			if (f.rd != '0 && (alu || f.opcode == OP_LOAD || f.opcode == OP_LDI)) begin
				modelRegs[f.rd] = r;
				expWb.push_back({1'b1, f.rd, r});
				expFlags.push_back(modelFlags);
			end
			cur = next;
			next = after;
		end
	endfunction

	//////////////////////////////////////////////////////////////////////
	task automatic resetDut();
		@(posedge clk);
		rst <= 1'b0;
		run <= 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b1;
		modelReset();
	endtask

	task automatic loadProgram();
		foreach (code[i]) begin
			@(posedge clk);
			prog.we   <= 1'b1;
			prog.addr <= pcAddr_t'(i);
			prog.data <= code[i];
		end
		@(posedge clk);
		prog.we <= 1'b0;
	endtask

	// keeps collecting a few cycles past the count to catch extra write-backs
	task automatic runUntil(int count, int maxCycles);
		int cycles;
		int settle;
		gotWb.delete();
		gotFlags.delete();
		cycles = 0;
		settle = 0;
		@(posedge clk);
		run <= 1'b1;
		while (settle < 8 && cycles < maxCycles) begin
			@(negedge clk);
			cycles++;
			if (wb.valid) begin
				gotWb.push_back(wb);
				gotFlags.push_back(flags);
			end
			if (gotWb.size() >= count) begin
				settle++;
			end
		end
		if (gotWb.size() < count) begin
			$display("timed out after %0d cycles with %0d of %0d write-backs seen",
				cycles, gotWb.size(), count);
			errors++;
		end
		@(posedge clk);
		run <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic runProgram();
		modelRun();
		loadProgram();
		runUntil(expWb.size(), 400);
		check("wb count", gotWb.size(), expWb.size());
		foreach (expWb[i]) begin
			if (i < gotWb.size()) begin
				check($sformatf("wb[%0d].dest", i), gotWb[i].dest, expWb[i].dest);
				check($sformatf("wb[%0d].data", i), gotWb[i].data, expWb[i].data);
				check($sformatf("flags at wb[%0d]", i), gotFlags[i], expFlags[i]);
			end
		end
	endtask

	task automatic finishTest(string name);
		testsRun++;
		if (errors == errorsBefore) begin
			$display("%s: passed", name);
		end else begin
			$display("%s: %0d errors", name, errors - errorsBefore);
		end
		errorsBefore = errors;
	endtask

	//////////////////////////////////////////////////////////////////////
	task automatic aluOps();
		code.delete();
		for (int i = 1; i <= 4; i++) begin
			emit(OP_LDI, i, 0, 1'b0, $urandom);
		end
		// results aimed at r0 are dropped
		emit(OP_ADD, 0, 1, 1'b0, 2);
		emit(OP_LDI, 0, 0, 1'b0, 16'h5a5a);
		for (int op = 1; op <= 5; op++) begin
			emit(opcode_e'(op), 5, 1, 1'b0, 2);
			emit(opcode_e'(op), 6, 3, 1'b1, $urandom);
		end
		addHalt();
		runProgram();
		finishTest("alu operations");
	endtask

	task automatic compareAndShift();
		code.delete();
		emit(OP_LDI, 1, 0, 1'b0, 16'h8000);
		emit(OP_LDI, 2, 0, 1'b0, 5);
		emit(OP_LDI, 3, 0, 1'b0, 16'hfff0);
		emit(OP_LDI, 4, 0, 1'b0, 16'h7fff);
		emit(OP_SLT, 5, 1, 1'b0, 2);
		emit(OP_SLT, 6, 2, 1'b0, 1);
		emit(OP_SLT, 7, 3, 1'b0, 2);
		emit(OP_SLT, 8, 2, 1'b1, 5);
		for (int k = 0; k < 4; k++) begin
			emit(OP_SHL, 9 + k, 3, 1'b1, k);
		end
		// wrap to zero, signed overflow both ways, borrow
		emit(OP_ADD, 13, 3, 1'b1, 16'h0010);
		emit(OP_ADD, 14, 4, 1'b1, 1);
		emit(OP_SUB, 15, 2, 1'b0, 2);
		emit(OP_SUB, 16, 1, 1'b1, 1);
		emit(OP_SUB, 17, 2, 1'b1, 6);
		emit(OP_XOR, 18, 4, 1'b0, 4);
		addHalt();
		runProgram();
		finishTest("compare, shift and flags");
	endtask

	task automatic dataMemory();
		code.delete();
		emit(OP_LDI, 1, 0, 1'b0, $urandom);
		for (int i = 2; i <= 5; i++) begin
			emit(OP_LDI, i, 0, 1'b0, $urandom);
		end
		emit(OP_STORE, 2, 1, 1'b1, 0);
		emit(OP_STORE, 3, 1, 1'b1, 7);
		emit(OP_STORE, 4, 0, 1'b1, 16'h00f0);
		emit(OP_STORE, 5, 1, 1'b1, 16'h00c5);
		emit(OP_LOAD, 6, 1, 1'b1, 0);
		emit(OP_LOAD, 7, 1, 1'b1, 7);
		emit(OP_LOAD, 8, 0, 1'b1, 16'h00f0);
		emit(OP_LOAD, 9, 1, 1'b1, 16'h00c5);
		addHalt();
		runProgram();
		finishTest("data memory");
	endtask

	task automatic controlFlow();
		int n;
		n = 3 + ($urandom % 6);
		code.delete();
		emit(OP_LDI, 1, 0, 1'b0, 100);
		emit(OP_JMP, 0, 0, 1'b0, 4);
		emit(OP_LDI, 2, 0, 1'b0, 7);
		emit(OP_LDI, 3, 0, 1'b0, 99);
		emit(OP_LDI, 4, 0, 1'b0, n);
		emit(OP_LDI, 5, 0, 1'b0, 0);
		// loop body at 6 with the delay slot at 9 running every pass
		emit(OP_ADD, 5, 5, 1'b1, 3);
		emit(OP_SUB, 4, 4, 1'b1, 1);
		emit(OP_BNZ, 4, 0, 1'b0, 6);
		emit(OP_ADD, 6, 5, 1'b1, 0);
		addHalt();
		runProgram();
		check("loop wb count", gotWb.size(), 4 + 3 * n);
		finishTest("control flow");
	endtask

	task automatic displayDigits();
		code.delete();
		for (int i = 1; i <= 4; i++) begin
			emit(OP_LDI, i, 0, 1'b0, $urandom);
		end
		addHalt();
		runProgram();
		@(negedge clk);
		check("hex", hex, hexOf(expWb[expWb.size() - 1].data));
		// reset lands while the program is writing back again
		@(posedge clk);
		run <= 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		resetDut();
		@(negedge clk);
		check("hex after reset", hex, hexOf('0));
		check("wb.valid after reset", wb.valid, 1'b0);
		check("flags after reset", flags, '0);
		check("pc after reset", pc, '0);
		finishTest("display");
	endtask

	task automatic holdAndRestart();
		int seen;
		int cycles;
		code.delete();
		for (int i = 0; i < 12; i++) begin
			emit(OP_LDI, 1 + i, 0, 1'b0, 16'h0100 + i);
		end
		addHalt();
		loadProgram();
		seen = 0;
		cycles = 0;
		@(posedge clk);
		run <= 1'b1;
		while (seen < 3 && cycles < 100) begin
			@(negedge clk);
			cycles++;
			if (wb.valid) begin
				check("wb.data before hold", wb.data, 16'h0100 + seen);
				seen++;
			end
		end
		if (seen < 3) begin
			$display("program did not start within %0d cycles", cycles);
			errors++;
		end
		@(posedge clk);
		run <= 1'b0;
		repeat (2) @(posedge clk);
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			check("pc while held", pc, '0);
			check("wb.valid while held", wb.valid, 1'b0);
		end
		// registers hit by the cut-off run are written again before use
		code.delete();
		emit(OP_LDI, 1, 0, 1'b0, $urandom);
		emit(OP_LDI, 2, 0, 1'b0, $urandom);
		emit(OP_ADD, 3, 1, 1'b0, 2);
		emit(OP_XOR, 4, 3, 1'b1, $urandom);
		addHalt();
		runProgram();
		finishTest("hold and restart");
	endtask

	initial begin
		void'($urandom(32'h462d_72e1));
		rst  = 1'b0;
		run  = 1'b0;
		prog = '0;
		foreach (modelMem[i]) begin
			modelMem[i] = '0;
		end
		resetDut();
		aluOps();
		compareAndShift();
		dataMemory();
		controlFlow();
		displayDigits();
		holdAndRestart();
		errors += u_cpuTop.u_cpuTopProps.failCount;
		$display("%0d tests run, %0d errors", testsRun, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: cpuTop.f
common/cpuPkg.sv
core/instMem.sv
core/instDecoder.sv
core/alu.sv
core/regFile.sv
core/cpuCore.sv
logic/hexDisplay.sv
logic/cpuTop.sv
verif/cpuTop_props.sv
verif/cpuTop_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench with verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module cpuTop_tb -f cpuTop.f -o simCpu

./obj_dir/simCpu +verilator+error+limit+100 | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
